//--- bench/recovery_rx_props.sv
module recovery_rx_props (
  input logic        clk_i,
  input logic        rst_ni,
  input logic        tok_valid_i,
  input logic        credit_o,
  input logic        payload_valid_o,
  input logic        payload_credit_i,
  input logic        cmd_valid_o,
  input logic        cmd_is_rd_o,
  input logic [7:0]  cmd_code_o,
  input logic [15:0] cmd_len_o,
  input logic        cmd_error_o,
  input logic        cmd_done_i
);
  timeunit 1ns;
  timeprecision 100ps;

  int fails;
  int up_cnt_q;
  int pay_cnt_q;

  // Credits held by the upstream and credits granted to the egress
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      up_cnt_q  <= int'(rcv_link_pkg::RxCredits);
      pay_cnt_q <= 0;
    end else begin
      up_cnt_q  <= up_cnt_q - int'(tok_valid_i) + int'(credit_o);
      pay_cnt_q <= pay_cnt_q + int'(payload_credit_i) - int'(payload_valid_o);
    end
  end

  tok_needs_credit: assert property (@(posedge clk_i) disable iff (!rst_ni)
    tok_valid_i |-> up_cnt_q > 0)
    else begin
      fails++;
      $error("token sent without an upstream credit");
    end

  pay_needs_credit: assert property (@(posedge clk_i) disable iff (!rst_ni)
    payload_valid_o |-> pay_cnt_q > 0)
    else begin
      fails++;
      $error("payload byte delivered without a downstream credit");
    end

  // Report holds steady until the downstream takes it
  cmd_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cmd_valid_o && !cmd_done_i |=> cmd_valid_o &&
      $stable({cmd_is_rd_o, cmd_code_o, cmd_len_o, cmd_error_o}))
    else begin
      fails++;
      $error("command report dropped or changed before cmd_done_i");
    end

  quiet_in_reset: assert property (@(posedge clk_i)
    !rst_ni |-> !credit_o && !payload_valid_o && !cmd_valid_o)
    else begin
      fails++;
      $error("output active during reset");
    end

endmodule

//--- bench/recovery_rx_tb.sv
module recovery_rx_tb;
  timeunit 1ns;
  timeprecision 100ps;

  typedef logic [7:0] byte_q_t[$];

  localparam int Timeout = 4000;

  logic                    clk_i;
  logic                    rst_ni;
  logic                    recovery_enable_i;
  logic                    tok_valid_i;
  rcv_link_pkg::tok_kind_e tok_kind_i;
  logic [7:0]              tok_data_i;
  logic                    credit_o;
  logic                    payload_valid_o;
  logic [7:0]              payload_data_o;
  logic                    payload_credit_i;
  logic                    cmd_valid_o;
  logic                    cmd_is_rd_o;
  logic [7:0]              cmd_code_o;
  logic [15:0]             cmd_len_o;
  logic                    cmd_error_o;
  logic                    cmd_done_i;

  // Expected traffic and the payload count due before each report
  logic [7:0]             exp_pay[$];
  recovery_pkg::cmd_rec_t exp_cmd[$];
  int                     exp_pay_before[$];

  string test_name;
  int    errors;
  int    tests;
  int    err_start;
  int    sent_cnt;
  int    returned_cnt;
  int    pay_sent;
  int    pay_seen;
  int    outstanding;
  int    credit_pct;
  logic  cmd_valid_q;

  recovery_rx_top DUT (.*);

  bind recovery_rx_top recovery_rx_props u_props (.*);

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // Bitwise MSB-first CRC-8 reference
  function automatic logic [7:0] pec_ref(input byte_q_t bytes);
    logic [7:0] crc;
    logic       fb;
    crc = 8'h00;
    foreach (bytes[i]) begin
      for (int b = 7; b >= 0; b--) begin
        fb  = crc[7] ^ bytes[i][b];
        crc = {crc[6:0], 1'b0};
        if (fb) begin
          crc = crc ^ recovery_pkg::PecPoly;
        end
      end
    end
    return crc;
  endfunction

  function automatic int total_errors();
    return errors + DUT.u_props.fails;
  endfunction

  task automatic finish_run();
    $display("%0d tests run, %0d errors", tests, total_errors());
    if (total_errors() == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  endtask

  task automatic stop_on_timeout(input string what);
    errors++;
    $display("%s: timed out, %s", test_name, what);
    finish_run();
  endtask

  // Upstream returns credits with one-cycle credit_o pulses
  always @(posedge clk_i) begin
    if (credit_o) begin
      returned_cnt <= returned_cnt + 1;
    end
  end

  // Random downstream credits with at most PayCredits outstanding
  always @(negedge clk_i) begin
    if (rst_ni) begin
      if (payload_valid_o) begin
        outstanding--;
      end
      if (outstanding < int'(rcv_link_pkg::PayCredits) &&
          $urandom_range(99) < credit_pct) begin
        payload_credit_i = 1'b1;
        outstanding++;
      end else begin
        payload_credit_i = 1'b0;
      end
    end
  end

  initial begin : done_driver
    int delay;
    forever begin
      @(negedge clk_i);
      if (cmd_valid_o) begin
        delay = $urandom_range(5, 1);
        repeat (delay - 1) @(negedge clk_i);
        cmd_done_i = 1'b1;
        @(negedge clk_i);
        cmd_done_i = 1'b0;
      end
    end
  end

  always @(negedge clk_i) begin : compare
    recovery_pkg::cmd_rec_t got;
    recovery_pkg::cmd_rec_t exp;
    logic [7:0]             exp_b;
    int                     exp_n;
    if (payload_valid_o) begin
      if (exp_pay.size() == 0) begin
        errors++;
        $display("%s: unexpected payload byte %h", test_name, payload_data_o);
      end else begin
        exp_b = exp_pay.pop_front();
        if (payload_data_o !== exp_b) begin
          errors++;
          $display("mismatch %s: payload expected %h actual %h",
                   test_name, exp_b, payload_data_o);
        end
      end
      pay_seen++;
    end
    if (cmd_valid_o && !cmd_valid_q) begin
      got = '{is_rd: cmd_is_rd_o, code: cmd_code_o, len: cmd_len_o, error: cmd_error_o};
      if (exp_cmd.size() == 0) begin
        errors++;
        $display("%s: unexpected command report %h", test_name, got);
      end else begin
        exp   = exp_cmd.pop_front();
        exp_n = exp_pay_before.pop_front();
        if (got !== exp) begin
          errors++;
          $display("mismatch %s: command expected %h actual %h", test_name, exp, got);
        end
        if (pay_seen != exp_n) begin
          errors++;
          $display("mismatch %s: payload bytes before report expected %0d actual %0d",
                   test_name, exp_n, pay_seen);
        end
      end
    end
    cmd_valid_q = cmd_valid_o;
  end

  task automatic send_tok(input rcv_link_pkg::tok_kind_e kind, input logic [7:0] data);
    int waited;
    waited = 0;
    while (sent_cnt - returned_cnt >= int'(rcv_link_pkg::RxCredits)) begin
      @(negedge clk_i);
      waited++;
      if (waited > Timeout) begin
        stop_on_timeout("no upstream credit came back");
      end
    end
    tok_valid_i = 1'b1;
    tok_kind_i  = kind;
    tok_data_i  = data;
    sent_cnt++;
    @(negedge clk_i);
    tok_valid_i = 1'b0;
  endtask

  // Write frame that produces no output unless expected is set
  task automatic send_write(input logic [7:0] code, input logic [15:0] len,
                            input bit bad_pec, input bit expected);
    byte_q_t    crc_bytes;
    logic [7:0] b;
    logic [7:0] pec;
    crc_bytes = {code, len[7:0], len[15:8]};
    send_tok(rcv_link_pkg::TokStart, 8'h00);
    send_tok(rcv_link_pkg::TokByte, code);
    send_tok(rcv_link_pkg::TokByte, len[7:0]);
    send_tok(rcv_link_pkg::TokByte, len[15:8]);
    for (int i = 0; i < int'(len); i++) begin
      b = 8'($urandom);
      crc_bytes.push_back(b);
      if (expected) begin
        exp_pay.push_back(b);
      end
      send_tok(rcv_link_pkg::TokByte, b);
    end
    pec = pec_ref(crc_bytes) ^ (bad_pec ? 8'h5a : 8'h00);
    if (expected) begin
      pay_sent += int'(len);
      exp_pay_before.push_back(pay_sent);
      exp_cmd.push_back('{is_rd: 1'b0, code: code, len: len, error: bad_pec});
    end
    send_tok(rcv_link_pkg::TokByte, pec);
    send_tok(rcv_link_pkg::TokStop, 8'h00);
  endtask

  task automatic send_read(input logic [7:0] code, input bit bad_pec);
    byte_q_t    crc_bytes;
    logic [7:0] pec;
    crc_bytes.push_back(code);
    pec = pec_ref(crc_bytes) ^ (bad_pec ? 8'h5a : 8'h00);
    exp_pay_before.push_back(pay_sent);
    exp_cmd.push_back('{is_rd: 1'b1, code: code, len: 16'h0000, error: bad_pec});
    send_tok(rcv_link_pkg::TokStart, 8'h00);
    send_tok(rcv_link_pkg::TokByte, code);
    send_tok(rcv_link_pkg::TokByte, pec);
    send_tok(rcv_link_pkg::TokStart, 8'h00);
    send_tok(rcv_link_pkg::TokStop, 8'h00);
  endtask

  // Aborted write whose partial payload still comes out
  task automatic send_abort(input logic [7:0] code, input logic [15:0] len, input int part);
    logic [7:0] b;
    send_tok(rcv_link_pkg::TokStart, 8'h00);
    send_tok(rcv_link_pkg::TokByte, code);
    send_tok(rcv_link_pkg::TokByte, len[7:0]);
    send_tok(rcv_link_pkg::TokByte, len[15:8]);
    for (int i = 0; i < part; i++) begin
      b = 8'($urandom);
      exp_pay.push_back(b);
      send_tok(rcv_link_pkg::TokByte, b);
    end
    pay_sent += part;
    send_tok(rcv_link_pkg::TokStop, 8'h00);
  endtask

  // Everything expected has arrived and all upstream credits are back
  task automatic wait_idle();
    int waited;
    waited = 0;
    while (exp_pay.size() != 0 || exp_cmd.size() != 0 ||
           sent_cnt != returned_cnt || cmd_valid_o) begin
      @(negedge clk_i);
      waited++;
      if (waited > Timeout) begin
        stop_on_timeout("traffic did not drain");
      end
    end
    // Quiet window to catch stray outputs
    repeat (12) @(negedge clk_i);
  endtask

  task automatic start_test(input string name);
    test_name = name;
    err_start = total_errors();
  endtask

  task automatic end_test();
    wait_idle();
    tests++;
    $display("test %s finished with %0d errors", test_name, total_errors() - err_start);
  endtask

  initial begin : main
    void'($urandom(32'h1665_9d6d));
    rst_ni            = 1'b0;
    recovery_enable_i = 1'b1;
    tok_valid_i       = 1'b0;
    tok_kind_i        = rcv_link_pkg::TokByte;
    tok_data_i        = 8'h00;
    payload_credit_i  = 1'b0;
    cmd_done_i        = 1'b0;
    credit_pct        = 60;
    test_name         = "reset";
    repeat (3) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);

    start_test("write_random");
    send_write(8'($urandom), 16'd0, 1'b0, 1'b1);
    for (int i = 0; i < 8; i++) begin
      send_write(8'($urandom), 16'($urandom_range(12, 0)), 1'b0, 1'b1);
    end
    end_test();

    start_test("read_frame");
    send_read(8'($urandom), 1'b0);
    send_read(8'($urandom), 1'b1);
    end_test();

    start_test("write_bad_pec");
    send_write(8'($urandom), 16'd5, 1'b1, 1'b1);
    end_test();

    start_test("stop_abort");
    send_abort(8'($urandom), 16'd10, 3);
    send_write(8'($urandom), 16'd4, 1'b0, 1'b1);
    end_test();

    // Sparse credits keep the egress FIFO full
    start_test("backpressure");
    credit_pct = 8;
    for (int i = 0; i < 6; i++) begin
      if (i == 2) begin
        send_read(8'($urandom), 1'b0);
      end else begin
        send_write(8'($urandom), 16'($urandom_range(12, 8)), 1'b0, 1'b1);
      end
    end
    end_test();
    credit_pct = 60;

    start_test("recovery_disabled");
    recovery_enable_i = 1'b0;
    send_write(8'($urandom), 16'd6, 1'b0, 1'b0);
    wait_idle();
    recovery_enable_i = 1'b1;
    send_write(8'($urandom), 16'd3, 1'b0, 1'b1);
    end_test();

    finish_run();
  end

endmodule

//--- flist.f
logic/rcv_link_pkg.sv
logic/recovery_pkg.sv
logic/rx_tok_if.sv
logic/cmd_rec_if.sv
logic/rx_tok_buffer.sv
logic/pec_crc8.sv
logic/recovery_cmd_parser.sv
logic/payload_egress.sv
logic/recovery_rx_top.sv
bench/recovery_rx_props.sv
bench/recovery_rx_tb.sv

//--- logic/cmd_rec_if.sv
interface cmd_rec_if;

  // Payload byte stream
  logic                   pay_valid;
  logic [7:0]             pay_data;
  logic                   pay_full;

  // Command record handshake
  logic                   rec_valid;
  recovery_pkg::cmd_rec_t rec;
  logic                   rec_ack;

  modport prs (
    output pay_valid,
    output pay_data,
    input  pay_full,
    output rec_valid,
    output rec,
    input  rec_ack
  );

  modport egr (
    input  pay_valid,
    input  pay_data,
    output pay_full,
    input  rec_valid,
    input  rec,
    output rec_ack
  );

endinterface

//--- logic/payload_egress.sv
module payload_egress (
  input  logic        clk_i,
  input  logic        rst_ni,
  cmd_rec_if.egr      cmd,
  input  logic        payload_credit_i,
  output logic        payload_valid_o,
  output logic [7:0]  payload_data_o,
  input  logic        cmd_done_i,
  output logic        cmd_valid_o,
  output logic        cmd_is_rd_o,
  output logic [7:0]  cmd_code_o,
  output logic [15:0] cmd_len_o,
  output logic        cmd_error_o
);

  localparam int unsigned PtrW = $clog2(rcv_link_pkg::PayDepth);
  localparam int unsigned CntW = $clog2(rcv_link_pkg::PayDepth + 1);
  localparam int unsigned CrdW = $clog2(rcv_link_pkg::PayCredits + 1);

  logic [7:0]      mem_q [rcv_link_pkg::PayDepth];
  logic [PtrW-1:0] wr_ptr_q;
  logic [PtrW-1:0] rd_ptr_q;
  logic [CntW-1:0] count_q;
  logic [CrdW-1:0] credit_q;
  logic            push;
  logic            pop;

  recovery_pkg::cmd_rec_t rec_q;
  logic                   rec_pend_q;
  logic                   rec_ack_q;
  logic                   done;

  assign cmd.pay_full = (count_q == CntW'(rcv_link_pkg::PayDepth));
  assign push         = cmd.pay_valid & ~cmd.pay_full;

  // A byte leaves only against a downstream credit
  assign pop             = (count_q != '0) & (credit_q != '0);
  assign payload_valid_o = pop;
  assign payload_data_o  = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= cmd.pay_data;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      credit_q <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
      case ({payload_credit_i, pop})
        2'b10:   credit_q <= credit_q + 1'b1;
        2'b01:   credit_q <= credit_q - 1'b1;
        default: credit_q <= credit_q;
      endcase
    end
  end

  // Report only once all payload ahead of it has drained
  assign cmd_valid_o = rec_pend_q & (count_q == '0);
  assign done        = cmd_valid_o & cmd_done_i;

  // Parser keeps rec_valid up until the ack, so skip the ack cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rec_pend_q <= 1'b0;
      rec_ack_q  <= 1'b0;
    end else begin
      rec_ack_q <= done;
      if (done) begin
        rec_pend_q <= 1'b0;
      end else if (cmd.rec_valid && !rec_pend_q && !rec_ack_q) begin
        rec_pend_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (cmd.rec_valid && !rec_pend_q && !rec_ack_q) begin
      rec_q <= cmd.rec;
    end
  end

  assign cmd.rec_ack = rec_ack_q;
  assign cmd_is_rd_o = rec_q.is_rd;
  assign cmd_code_o  = rec_q.code;
  assign cmd_len_o   = rec_q.len;
  assign cmd_error_o = rec_q.error;

endmodule

//--- logic/pec_crc8.sv
module pec_crc8 (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       clear_i,
  input  logic       en_i,
  input  logic [7:0] data_i,
  output logic [7:0] crc_o
);

  logic [7:0] crc_q;
  logic [7:0] crc_next;

  // Fold one byte in, all eight bits in a single step
  always_comb begin
    crc_next = crc_q ^ data_i;
    for (int i = 0; i < 8; i++) begin
      if (crc_next[7]) begin
        crc_next = {crc_next[6:0], 1'b0} ^ recovery_pkg::PecPoly;
      end else begin
        crc_next = {crc_next[6:0], 1'b0};
      end
    end
  end

  // Clear wins over a byte in the same cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      crc_q <= '0;
    end else if (clear_i) begin
      crc_q <= '0;
    end else if (en_i) begin
      crc_q <= crc_next;
    end
  end

  assign crc_o = crc_q;

endmodule

//--- logic/rcv_link_pkg.sv
package rcv_link_pkg;

  // Token kinds on the upstream byte link
  typedef enum logic [1:0] {
    TokByte  = 2'd0,
    TokStart = 2'd1,
    TokStop  = 2'd2
  } tok_kind_e;

  // Input token FIFO
  localparam int unsigned RxDepth = 4;

  // Upstream starts with one credit per free input slot
  localparam int unsigned RxCredits = RxDepth;

  // Payload FIFO towards the downstream
  localparam int unsigned PayDepth = 8;

  // Most credits the downstream may have outstanding
  localparam int unsigned PayCredits = 4;

endpackage

//--- logic/recovery_cmd_parser.sv
module recovery_cmd_parser (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       enable_i,
  rx_tok_if.dst      tok,
  cmd_rec_if.prs     rec,
  output logic       crc_clear_o,
  output logic       crc_en_o,
  output logic [7:0] crc_data_o,
  input  logic [7:0] crc_i
);

  typedef enum logic [2:0] {
    Idle   = 3'd0,
    RxCmd  = 3'd1,
    RxLenL = 3'd2,
    RxLenH = 3'd3,
    RxData = 3'd4,
    RxPec  = 3'd5,
    Report = 3'd6
  } state_e;

  state_e state_q;
  state_e state_d;

  recovery_pkg::hdr_word_u         hdr_q;
  logic [7:0]                      code_q;
  logic [7:0]                      pec_snap_q;
  logic [recovery_pkg::MaxLen-1:0] len_cnt_q;
  logic [recovery_pkg::MaxLen-1:0] len_next;
  logic                            is_rd_q;
  logic                            error_q;

  logic take;
  logic is_byte;
  logic is_start;
  logic is_stop;
  logic in_frame;

  assign take     = tok.valid & tok.pop;
  assign is_byte  = take & (tok.kind == rcv_link_pkg::TokByte);
  assign is_start = take & (tok.kind == rcv_link_pkg::TokStart);
  assign is_stop  = take & (tok.kind == rcv_link_pkg::TokStop);
  assign in_frame = (state_q inside {RxCmd, RxLenL, RxLenH, RxData, RxPec});

  // Length as it stands once the high byte arrives
  assign len_next = {tok.data, hdr_q.len[7:0]};

  assign crc_data_o   = tok.data;
  assign rec.pay_data = tok.data;

  always_comb begin
    state_d       = state_q;
    tok.pop       = 1'b1;
    rec.pay_valid = 1'b0;
    crc_clear_o   = 1'b0;
    crc_en_o      = 1'b0;
    if (!enable_i) begin
      // Recovery off, drain everything
      state_d = Idle;
    end else begin
      case (state_q)
        Idle: begin
          if (is_start) begin
            crc_clear_o = 1'b1;
            state_d     = RxCmd;
          end
        end
        RxCmd: begin
          if (is_byte) begin
            crc_en_o = 1'b1;
            state_d  = RxLenL;
          end
        end
        RxLenL: begin
          if (is_byte) begin
            crc_en_o = 1'b1;
            state_d  = RxLenH;
          end
        end
        RxLenH: begin
          if (is_byte) begin
            crc_en_o = 1'b1;
            state_d  = (len_next == '0) ? RxPec : RxData;
          end else if (is_start) begin
            // Repeated start, this was a read
            state_d = Report;
          end
        end
        RxData: begin
          // Hold a byte back while the egress is full, control tokens still go
          tok.pop       = (tok.kind != rcv_link_pkg::TokByte) | ~rec.pay_full;
          rec.pay_valid = tok.valid & (tok.kind == rcv_link_pkg::TokByte);
          if (is_byte) begin
            crc_en_o = 1'b1;
            if (len_cnt_q == 1) begin
              state_d = RxPec;
            end
          end
        end
        RxPec: begin
          if (is_byte) begin
            state_d = Report;
          end
        end
        Report: begin
          tok.pop = 1'b0;
          if (rec.rec_ack) begin
            state_d = Idle;
          end
        end
        default: state_d = Idle;
      endcase

      // Stop aborts a frame; a stray start begins a new one
      if (in_frame) begin
        if (is_stop) begin
          state_d = Idle;
        end else if (is_start && state_q != RxLenH) begin
          crc_clear_o = 1'b1;
          state_d     = RxCmd;
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= Idle;
    end else begin
      state_q <= state_d;
    end
  end

  // Header capture, length count and PEC verdict
  always_ff @(posedge clk_i) begin
    case (state_q)
      RxCmd: begin
        if (is_byte) begin
          code_q <= tok.data;
        end
      end
      RxLenL: begin
        if (is_byte) begin
          hdr_q.len[7:0] <= tok.data;
          // CRC over the command only, expected PEC of a read
          pec_snap_q     <= crc_i;
        end
      end
      RxLenH: begin
        if (is_byte) begin
          hdr_q.len[15:8] <= tok.data;
          len_cnt_q       <= len_next;
        end else if (is_start) begin
          is_rd_q <= 1'b1;
          error_q <= (hdr_q.rd.pec != pec_snap_q);
        end
      end
      RxData: begin
        if (is_byte) begin
          len_cnt_q <= len_cnt_q - 1'b1;
        end
      end
      RxPec: begin
        if (is_byte) begin
          is_rd_q <= 1'b0;
          error_q <= (tok.data != crc_i);
        end
      end
      default: begin
      end
    endcase
  end

  assign rec.rec_valid = (state_q == Report);
  assign rec.rec.is_rd = is_rd_q;
  assign rec.rec.code  = code_q;
  assign rec.rec.len   = is_rd_q ? '0 : hdr_q.len;
  assign rec.rec.error = error_q;

endmodule

//--- logic/recovery_pkg.sv
package recovery_pkg;

  // CRC-8 polynomial of the packet error code, MSB first
  localparam logic [7:0] PecPoly = 8'h07;

  // Width of the length field
  localparam int unsigned MaxLen = 16;

  // Read view of the two bytes after the command code
  typedef struct packed {
    logic [7:0] pad;
    logic [7:0] pec;
  } hdr_rd_t;

  // Second and third header bytes, length for a write or PEC for a read
  typedef union packed {
    logic [MaxLen-1:0] len;
    hdr_rd_t           rd;
  } hdr_word_u;

  // Decoded command handed to the output side
  typedef struct packed {
    logic              is_rd;
    logic [7:0]        code;
    logic [MaxLen-1:0] len;
    logic              error;
  } cmd_rec_t;

endpackage

//--- logic/recovery_rx_top.sv
module recovery_rx_top (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    recovery_enable_i,
  input  logic                    tok_valid_i,
  input  rcv_link_pkg::tok_kind_e tok_kind_i,
  input  logic [7:0]              tok_data_i,
  output logic                    credit_o,
  output logic                    payload_valid_o,
  output logic [7:0]              payload_data_o,
  input  logic                    payload_credit_i,
  output logic                    cmd_valid_o,
  output logic                    cmd_is_rd_o,
  output logic [7:0]              cmd_code_o,
  output logic [15:0]             cmd_len_o,
  output logic                    cmd_error_o,
  input  logic                    cmd_done_i
);

  logic       crc_clear;
  logic       crc_en;
  logic [7:0] crc_data;
  logic [7:0] crc;

  rx_tok_if  tok_link ();
  cmd_rec_if rec_link ();

  rx_tok_buffer u_rx_tok_buffer (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .tok_valid_i (tok_valid_i),
    .tok_kind_i  (tok_kind_i),
    .tok_data_i  (tok_data_i),
    .credit_o    (credit_o),
    .tok         (tok_link.src)
  );

  recovery_cmd_parser u_recovery_cmd_parser (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .enable_i    (recovery_enable_i),
    .tok         (tok_link.dst),
    .rec         (rec_link.prs),
    .crc_clear_o (crc_clear),
    .crc_en_o    (crc_en),
    .crc_data_o  (crc_data),
    .crc_i       (crc)
  );

  pec_crc8 u_pec_crc8 (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .clear_i (crc_clear),
    .en_i    (crc_en),
    .data_i  (crc_data),
    .crc_o   (crc)
  );

  payload_egress u_payload_egress (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .cmd              (rec_link.egr),
    .payload_credit_i (payload_credit_i),
    .payload_valid_o  (payload_valid_o),
    .payload_data_o   (payload_data_o),
    .cmd_done_i       (cmd_done_i),
    .cmd_valid_o      (cmd_valid_o),
    .cmd_is_rd_o      (cmd_is_rd_o),
    .cmd_code_o       (cmd_code_o),
    .cmd_len_o        (cmd_len_o),
    .cmd_error_o      (cmd_error_o)
  );

endmodule

//--- logic/rx_tok_buffer.sv
module rx_tok_buffer (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    tok_valid_i,
  input  rcv_link_pkg::tok_kind_e tok_kind_i,
  input  logic [7:0]              tok_data_i,
  output logic                    credit_o,
  rx_tok_if.src                   tok
);

  localparam int unsigned PtrW = $clog2(rcv_link_pkg::RxDepth);
  localparam int unsigned CntW = $clog2(rcv_link_pkg::RxDepth + 1);

  rcv_link_pkg::tok_kind_e kind_q [rcv_link_pkg::RxDepth];
  logic [7:0]              data_q [rcv_link_pkg::RxDepth];

  logic [PtrW-1:0] wr_ptr_q;
  logic [PtrW-1:0] rd_ptr_q;
  logic [CntW-1:0] count_q;
  logic            push;
  logic            pop;

  // Upstream only sends against a credit, so a push always finds room
  assign push = tok_valid_i;
  assign pop  = tok.valid & tok.pop;

  // Head of the FIFO
  assign tok.valid = (count_q != '0);
  assign tok.kind  = kind_q[rd_ptr_q];
  assign tok.data  = data_q[rd_ptr_q];

  // Storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      kind_q[wr_ptr_q] <= tok_kind_i;
      data_q[wr_ptr_q] <= tok_data_i;
    end
  end

  // Pointers and fill level
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // One credit back per token taken
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      credit_o <= 1'b0;
    end else begin
      credit_o <= pop;
    end
  end

endmodule

//--- logic/rx_tok_if.sv
interface rx_tok_if;

  // Head of the input FIFO
  logic                    valid;
  rcv_link_pkg::tok_kind_e kind;
  logic [7:0]              data;

  // Consume the head token
  logic                    pop;

  modport src (
    output valid,
    output kind,
    output data,
    input  pop
  );

  modport dst (
    input  valid,
    input  kind,
    input  data,
    output pop
  );

endinterface
